/* logic/dcache_pkg.sv */
package dcache_pkg;

    // front-end and memory port widths
    localparam int FE_ADDR_W = 32;
    localparam int FE_DATA_W = 32;
    localparam int FE_NBYTES = 4;

    localparam int CTRL_REG_W = 3;

    // control register map
    localparam logic [CTRL_REG_W-1:0] CTRL_RD_HIT     = 3'd0;
    localparam logic [CTRL_REG_W-1:0] CTRL_RD_MISS    = 3'd1;
    localparam logic [CTRL_REG_W-1:0] CTRL_WR_HIT     = 3'd2;
    localparam logic [CTRL_REG_W-1:0] CTRL_WR_MISS    = 3'd3;
    localparam logic [CTRL_REG_W-1:0] CTRL_STATUS     = 3'd4;
    localparam logic [CTRL_REG_W-1:0] CTRL_CLEAR      = 3'd5;
    localparam logic [CTRL_REG_W-1:0] CTRL_INVALIDATE = 3'd6;

    // one address word, seen either as a cache access or a control register
    typedef union packed {
        struct packed {
            logic                 ctrl;
            logic [FE_ADDR_W-4:0] word_addr;
            logic [1:0]           byte_off;
        } cache;
        struct packed {
            logic                            ctrl;
            logic [FE_ADDR_W-4-CTRL_REG_W:0] unused;
            logic [CTRL_REG_W-1:0]           reg_idx;
            logic [1:0]                      byte_off;
        } ctrl;
    } fe_addr_u;

endpackage

/* logic/cache_req_if.sv */
`timescale 1ns/10ps

interface cache_req_if;
    import dcache_pkg::*;

    // registered request, held until done
    logic                 valid;
    fe_addr_u             addr;
    logic [FE_DATA_W-1:0] wdata;
    logic [FE_NBYTES-1:0] wstrb;

    // answer from the cache-memory stage
    logic [FE_DATA_W-1:0] rdata;
    logic                 done;

    modport fe (output valid, addr, wdata, wstrb, input rdata, done);
    modport mem (input valid, addr, wdata, wstrb, output rdata, done);

endinterface

/* logic/mem_write_if.sv */
`timescale 1ns/10ps

interface mem_write_if;
    import dcache_pkg::*;

    // head entry of the write-through buffer
    logic                 valid;
    logic [FE_ADDR_W-4:0] addr;
    logic [FE_DATA_W-1:0] wdata;
    logic [FE_NBYTES-1:0] wstrb;
    // pops the head entry
    logic                 ready;

    modport src (output valid, addr, wdata, wstrb, input ready);
    modport snk (input valid, addr, wdata, wstrb, output ready);

endinterface

/* logic/line_refill_if.sv */
`timescale 1ns/10ps

interface line_refill_if #(
    parameter int WORD_OFF_W = 2
);
    import dcache_pkg::*;

    // line request, held until refill_done
    logic                            refill_valid;
    logic [FE_ADDR_W-4-WORD_OFF_W:0] line_addr;

    // one pulse per returned word
    logic                  word_valid;
    logic [WORD_OFF_W-1:0] word_idx;
    logic [FE_DATA_W-1:0]  word_data;
    logic                  refill_done;

    modport req (output refill_valid, line_addr,
                 input word_valid, word_idx, word_data, refill_done);
    modport rsp (input refill_valid, line_addr,
                 output word_valid, word_idx, word_data, refill_done);

endinterface

/* logic/cache_frontend.sv */
`timescale 1ns/10ps

module cache_frontend (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             valid,
    input  logic [dcache_pkg::FE_ADDR_W-1:0] addr,
    input  logic [dcache_pkg::FE_DATA_W-1:0] wdata,
    input  logic [dcache_pkg::FE_NBYTES-1:0] wstrb,
    output logic [dcache_pkg::FE_DATA_W-1:0] rdata,
    output logic                             ready,
    cache_req_if.fe                          req,
    output logic                              ctrl_valid,
    output logic [dcache_pkg::CTRL_REG_W-1:0] ctrl_reg,
    output logic [dcache_pkg::FE_DATA_W-1:0]  ctrl_wdata,
    output logic                              ctrl_we,
    input  logic [dcache_pkg::FE_DATA_W-1:0]  ctrl_rdata,
    input  logic                              ctrl_done
);
    import dcache_pkg::*;

    fe_addr_u addr_dec;
    logic     accept;

    assign addr_dec = addr;

    // take a new request only when both paths are idle
    assign accept = valid && !req.valid && !ctrl_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid  <= 1'b0;
            ctrl_valid <= 1'b0;
        end else if (accept) begin
            req.valid  <= !addr_dec.cache.ctrl;
            ctrl_valid <= addr_dec.cache.ctrl;
        end else begin
            if (req.done)
                req.valid <= 1'b0;
            if (ctrl_done)
                ctrl_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.addr  <= addr_dec;
            req.wdata <= wdata;
            req.wstrb <= wstrb;
            ctrl_reg  <= addr_dec.ctrl.reg_idx;
            ctrl_we   <= |wstrb;
        end
    end

    // both paths share the registered write data
    assign ctrl_wdata = req.wdata;

    assign ready = req.done | ctrl_done;
    assign rdata = ctrl_done ? ctrl_rdata : req.rdata;

endmodule

/* logic/cache_memory.sv */
`timescale 1ns/10ps

module cache_memory #(
    parameter int LINE_OFF_W    = 4,
    parameter int WORD_OFF_W    = 2,
    parameter int WTBUF_DEPTH_W = 2
) (
    input  logic       clk,
    input  logic       reset,
    cache_req_if.mem   req,
    mem_write_if.src   wr,
    line_refill_if.req refill,
    output logic       read_hit,
    output logic       read_miss,
    output logic       write_hit,
    output logic       write_miss,
    output logic       wtbuf_empty,
    input  logic       invalidate
);
    import dcache_pkg::*;

    localparam int WADDR_W     = FE_ADDR_W - 3;
    localparam int TAG_W       = WADDR_W - LINE_OFF_W - WORD_OFF_W;
    localparam int NLINES      = 2 ** LINE_OFF_W;
    localparam int NWORDS      = 2 ** (LINE_OFF_W + WORD_OFF_W);
    localparam int WTBUF_DEPTH = 2 ** WTBUF_DEPTH_W;

    logic [WADDR_W-1:0]    waddr;
    logic [TAG_W-1:0]      tag;
    logic [LINE_OFF_W-1:0] idx;
    logic [WORD_OFF_W-1:0] woff;

    logic [TAG_W-1:0]     tag_mem [NLINES];
    logic [NLINES-1:0]    line_valid;
    logic [FE_DATA_W-1:0] data_mem [NWORDS];

    logic is_write;
    logic hit;
    logic lookup;
    logic push;
    logic pop;
    logic miss_seen;
    logic wtbuf_full;

    // write-through buffer, pointers carry a wrap bit
    logic [WTBUF_DEPTH_W:0] wp;
    logic [WTBUF_DEPTH_W:0] rp;
    logic [WADDR_W-1:0]     wb_addr  [WTBUF_DEPTH];
    logic [FE_DATA_W-1:0]   wb_wdata [WTBUF_DEPTH];
    logic [FE_NBYTES-1:0]   wb_wstrb [WTBUF_DEPTH];

    assign waddr    = req.addr.cache.word_addr;
    assign tag      = waddr[WADDR_W-1 -: TAG_W];
    assign idx      = waddr[WORD_OFF_W +: LINE_OFF_W];
    assign woff     = waddr[WORD_OFF_W-1:0];
    assign is_write = |req.wstrb;
    assign hit      = line_valid[idx] && (tag_mem[idx] == tag);

    // one lookup per cycle while a request waits; writes need buffer room
    assign lookup = req.valid && !req.done && !refill.refill_valid
                    && !(is_write && wtbuf_full);
    assign push   = lookup && is_write;
    assign pop    = wr.valid && wr.ready;

    // the retry after a refill is not a second hit
    assign read_hit   = lookup && !is_write && hit && !miss_seen;
    assign read_miss  = lookup && !is_write && !hit;
    assign write_hit  = push && hit;
    assign write_miss = push && !hit;

    assign refill.line_addr = waddr[WADDR_W-1:WORD_OFF_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            req.done            <= 1'b0;
            refill.refill_valid <= 1'b0;
            miss_seen           <= 1'b0;
            line_valid          <= '0;
        end else begin
            req.done <= lookup && (is_write || hit);
            if (read_miss) begin
                refill.refill_valid <= 1'b1;
                miss_seen           <= 1'b1;
            end else if (refill.refill_done) begin
                refill.refill_valid <= 1'b0;
            end
            if (req.done)
                miss_seen <= 1'b0;
            if (invalidate)
                line_valid <= '0;
            else if (refill.refill_done)
                line_valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        req.rdata <= data_mem[{idx, woff}];
        if (refill.word_valid)
            data_mem[{idx, refill.word_idx}] <= refill.word_data;
        if (refill.refill_done)
            tag_mem[idx] <= tag;
        // no allocate on write, only lines that hit are updated
        if (write_hit) begin
            for (int b = 0; b < FE_NBYTES; b++) begin
                if (req.wstrb[b])
                    data_mem[{idx, woff}][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    assign wtbuf_empty = (wp == rp);
    assign wtbuf_full  = (wp[WTBUF_DEPTH_W] != rp[WTBUF_DEPTH_W])
                         && (wp[WTBUF_DEPTH_W-1:0] == rp[WTBUF_DEPTH_W-1:0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            wp <= '0;
            rp <= '0;
        end else begin
            if (push)
                wp <= wp + 1'b1;
            if (pop)
                rp <= rp + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            wb_addr[wp[WTBUF_DEPTH_W-1:0]]  <= waddr;
            wb_wdata[wp[WTBUF_DEPTH_W-1:0]] <= req.wdata;
            wb_wstrb[wp[WTBUF_DEPTH_W-1:0]] <= req.wstrb;
        end
    end

    assign wr.valid = !wtbuf_empty;
    assign wr.addr  = wb_addr[rp[WTBUF_DEPTH_W-1:0]];
    assign wr.wdata = wb_wdata[rp[WTBUF_DEPTH_W-1:0]];
    assign wr.wstrb = wb_wstrb[rp[WTBUF_DEPTH_W-1:0]];

    // occupancy stays below depth whenever an entry is added
    assert property (@(posedge clk) disable iff (reset)
        push |-> ((WTBUF_DEPTH_W+1)'(wp - rp) < WTBUF_DEPTH));

    // an answer only ever goes to a request the front end still holds
    assert property (@(posedge clk) disable iff (reset)
        req.done |-> req.valid);

endmodule

/* logic/cache_backend.sv */
`timescale 1ns/10ps

module cache_backend #(
    parameter int WORD_OFF_W = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    mem_write_if.snk                         wr,
    line_refill_if.rsp                       refill,
    output logic                             mem_valid,
    output logic [dcache_pkg::FE_ADDR_W-1:0] mem_addr,
    output logic [dcache_pkg::FE_DATA_W-1:0] mem_wdata,
    output logic [dcache_pkg::FE_NBYTES-1:0] mem_wstrb,
    input  logic [dcache_pkg::FE_DATA_W-1:0] mem_rdata,
    input  logic                             mem_ready
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_WRITE = 2'd1;
    localparam logic [1:0] ST_READ  = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    logic [1:0]            state;
    logic [WORD_OFF_W-1:0] word_cnt;
    logic                  last_word;

    assign last_word = &word_cnt;

    assign wr.ready           = (state == ST_WRITE) && mem_ready;
    assign refill.word_valid  = (state == ST_READ) && mem_valid && mem_ready;
    assign refill.word_idx    = word_cnt;
    assign refill.word_data   = mem_rdata;
    assign refill.refill_done = (state == ST_DONE);

    // buffered writes go first, so a refill always reads current memory
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            mem_valid <= 1'b0;
            mem_wstrb <= '0;
            word_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr.valid) begin
                        mem_valid <= 1'b1;
                        mem_wstrb <= wr.wstrb;
                        state     <= ST_WRITE;
                    end else if (refill.refill_valid) begin
                        mem_wstrb <= '0;
                        word_cnt  <= '0;
                        state     <= ST_READ;
                    end
                end
                ST_WRITE: begin
                    if (mem_ready) begin
                        mem_valid <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    // one idle cycle between words
                    if (!mem_valid) begin
                        mem_valid <= 1'b1;
                    end else if (mem_ready) begin
                        mem_valid <= 1'b0;
                        word_cnt  <= word_cnt + 1'b1;
                        if (last_word)
                            state <= ST_DONE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && wr.valid) begin
            mem_addr  <= {1'b0, wr.addr, 2'b00};
            mem_wdata <= wr.wdata;
        end else if (state == ST_READ && !mem_valid) begin
            mem_addr <= {1'b0, refill.line_addr, word_cnt, 2'b00};
        end
    end

    // request fields hold until memory takes them
    assert property (@(posedge clk) disable iff (reset)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr)
            && $stable(mem_wdata) && $stable(mem_wstrb));

endmodule

/* logic/cache_control.sv */
`timescale 1ns/10ps

module cache_control (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              ctrl_valid,
    input  logic [dcache_pkg::CTRL_REG_W-1:0] ctrl_reg,
    input  logic [dcache_pkg::FE_DATA_W-1:0]  ctrl_wdata,
    input  logic                              ctrl_we,
    output logic [dcache_pkg::FE_DATA_W-1:0]  ctrl_rdata,
    output logic                              ctrl_done,
    input  logic                              read_hit,
    input  logic                              read_miss,
    input  logic                              write_hit,
    input  logic                              write_miss,
    input  logic                              wtbuf_empty,
    output logic                              invalidate
);
    import dcache_pkg::*;

    logic [FE_DATA_W-1:0] counters [4];
    logic [3:0]           events;
    logic                 access;
    logic                 clear;

    // order follows the register map
    assign events = {write_miss, write_hit, read_miss, read_hit};

    assign access     = ctrl_valid && !ctrl_done;
    assign clear      = access && ctrl_we && (ctrl_reg == CTRL_CLEAR);
    assign invalidate = access && ctrl_we && (ctrl_reg == CTRL_INVALIDATE);

    // bit i of the CLEAR data selects counter i
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (reset || (clear && ctrl_wdata[i]))
                counters[i] <= '0;
            else if (events[i] && counters[i] != '1)
                counters[i] <= counters[i] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            ctrl_done <= 1'b0;
        else
            ctrl_done <= access;
    end

    always_ff @(posedge clk) begin
        case (ctrl_reg)
            CTRL_RD_HIT, CTRL_RD_MISS, CTRL_WR_HIT, CTRL_WR_MISS:
                ctrl_rdata <= counters[ctrl_reg[1:0]];
            CTRL_STATUS:
                ctrl_rdata <= {{(FE_DATA_W-1){1'b0}}, wtbuf_empty};
            default:
                ctrl_rdata <= '0;
        endcase
    end

endmodule

/* logic/dcache.sv */
`timescale 1ns/10ps

module dcache #(
    parameter int LINE_OFF_W    = 4,
    parameter int WORD_OFF_W    = 2,
    parameter int WTBUF_DEPTH_W = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             valid,
    input  logic [dcache_pkg::FE_ADDR_W-1:0] addr,
    input  logic [dcache_pkg::FE_DATA_W-1:0] wdata,
    input  logic [dcache_pkg::FE_NBYTES-1:0] wstrb,
    output logic [dcache_pkg::FE_DATA_W-1:0] rdata,
    output logic                             ready,
    output logic                             mem_valid,
    output logic [dcache_pkg::FE_ADDR_W-1:0] mem_addr,
    output logic [dcache_pkg::FE_DATA_W-1:0] mem_wdata,
    output logic [dcache_pkg::FE_NBYTES-1:0] mem_wstrb,
    input  logic [dcache_pkg::FE_DATA_W-1:0] mem_rdata,
    input  logic                             mem_ready,
    output logic                             wtb_empty_o
);
    import dcache_pkg::*;

    cache_req_if req_if ();
    mem_write_if wr_if ();
    line_refill_if #(.WORD_OFF_W(WORD_OFF_W)) refill_if ();

    logic                  ctrl_valid;
    logic [CTRL_REG_W-1:0] ctrl_reg;
    logic [FE_DATA_W-1:0]  ctrl_wdata;
    logic                  ctrl_we;
    logic [FE_DATA_W-1:0]  ctrl_rdata;
    logic                  ctrl_done;
    logic                  read_hit;
    logic                  read_miss;
    logic                  write_hit;
    logic                  write_miss;
    logic                  wtbuf_empty;
    logic                  invalidate;

    assign wtb_empty_o = wtbuf_empty;

    cache_frontend front_end (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .addr      (addr),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .rdata     (rdata),
        .ready     (ready),
        .req       (req_if.fe),
        .ctrl_valid(ctrl_valid),
        .ctrl_reg  (ctrl_reg),
        .ctrl_wdata(ctrl_wdata),
        .ctrl_we   (ctrl_we),
        .ctrl_rdata(ctrl_rdata),
        .ctrl_done (ctrl_done)
    );

    cache_memory #(
        .LINE_OFF_W   (LINE_OFF_W),
        .WORD_OFF_W   (WORD_OFF_W),
        .WTBUF_DEPTH_W(WTBUF_DEPTH_W)
    ) cache_memory (
        .clk        (clk),
        .reset      (reset),
        .req        (req_if.mem),
        .wr         (wr_if.src),
        .refill     (refill_if.req),
        .read_hit   (read_hit),
        .read_miss  (read_miss),
        .write_hit  (write_hit),
        .write_miss (write_miss),
        .wtbuf_empty(wtbuf_empty),
        .invalidate (invalidate)
    );

    cache_backend #(
        .WORD_OFF_W(WORD_OFF_W)
    ) back_end (
        .clk      (clk),
        .reset    (reset),
        .wr       (wr_if.snk),
        .refill   (refill_if.rsp),
        .mem_valid(mem_valid),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready)
    );

    cache_control cache_control (
        .clk        (clk),
        .reset      (reset),
        .ctrl_valid (ctrl_valid),
        .ctrl_reg   (ctrl_reg),
        .ctrl_wdata (ctrl_wdata),
        .ctrl_we    (ctrl_we),
        .ctrl_rdata (ctrl_rdata),
        .ctrl_done  (ctrl_done),
        .read_hit   (read_hit),
        .read_miss  (read_miss),
        .write_hit  (write_hit),
        .write_miss (write_miss),
        .wtbuf_empty(wtbuf_empty),
        .invalidate (invalidate)
    );

endmodule

/* verif/dcache_tb.sv */
`timescale 1ns/10ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int LINE_OFF_W    = 4;
    localparam int WORD_OFF_W    = 2;
    localparam int WTBUF_DEPTH_W = 2;
    localparam int WADDR_W       = FE_ADDR_W - 3;
    localparam int NLINES        = 2 ** LINE_OFF_W;

    localparam int NUM_DIRECTED = 80;
    localparam int NUM_RANDOM   = 200;
    localparam int LAT_MAX      = 16;
    // worst request drains a full buffer and then refills a whole line
    localparam int MISS_CYCLES = (2 ** WORD_OFF_W + 2 ** WTBUF_DEPTH_W) * (LAT_MAX + 3) + 8;
    localparam int TIMEOUT_NS  = (NUM_DIRECTED + NUM_RANDOM) * MISS_CYCLES * 10;

    localparam int KIND_NONE  = 0;
    localparam int KIND_WORD  = 1;
    localparam int KIND_COUNT = 2;

    logic                 clk;
    logic                 reset;
    logic                 valid;
    logic [FE_ADDR_W-1:0] addr;
    logic [FE_DATA_W-1:0] wdata;
    logic [FE_NBYTES-1:0] wstrb;
    logic [FE_DATA_W-1:0] rdata;
    logic                 ready;
    logic                 mem_valid;
    logic [FE_ADDR_W-1:0] mem_addr;
    logic [FE_DATA_W-1:0] mem_wdata;
    logic [FE_NBYTES-1:0] mem_wstrb;
    logic [FE_DATA_W-1:0] mem_rdata;
    logic                 mem_ready;
    logic                 wtb_empty_o;

    integer seed = 32'hbbf5;
    string  cur_test = "reset";

    // expected responses, in request order
    logic [FE_DATA_W-1:0] exp_q [$];
    int                   kind_q [$];
    string                name_q [$];

    // processor view of memory, and shadow tags for hit/miss prediction
    logic [FE_DATA_W-1:0] ref_mem [logic [WADDR_W-1:0]];
    logic [NLINES-1:0]    sh_valid;
    logic [WADDR_W-1:0]   sh_tag [NLINES];
    logic [FE_DATA_W-1:0] event_count [4];
    int                   writes_issued;

    // memory model state
    logic [FE_DATA_W-1:0] mem_data [logic [WADDR_W-1:0]];
    int                   lat_min;
    int                   lat_span;
    logic                 mem_busy;
    int                   mem_wait;
    int                   mem_writes;

    dcache #(
        .LINE_OFF_W   (LINE_OFF_W),
        .WORD_OFF_W   (WORD_OFF_W),
        .WTBUF_DEPTH_W(WTBUF_DEPTH_W)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .valid      (valid),
        .addr       (addr),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .rdata      (rdata),
        .ready      (ready),
        .mem_valid  (mem_valid),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_wstrb  (mem_wstrb),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .wtb_empty_o(wtb_empty_o)
    );

    always #5 clk = ~clk;

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [FE_DATA_W-1:0] exp,
                              input logic [FE_DATA_W-1:0] act);
        if (act !== exp)
            stop_with_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_count(input string name, input logic [FE_DATA_W-1:0] exp,
                               input logic [FE_DATA_W-1:0] act);
        if (act !== exp)
            stop_with_error($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_with_error($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    // every address bit shows up in the initial word
    function automatic logic [FE_DATA_W-1:0] init_word(input logic [WADDR_W-1:0] wa);
        return {wa, 3'b101} ^ {wa[15:0], wa[28:13]} ^ 32'h6c8e_9cf5;
    endfunction

    function automatic logic [FE_DATA_W-1:0] merge_bytes(input logic [FE_DATA_W-1:0] base,
                                                         input logic [FE_DATA_W-1:0] data,
                                                         input logic [FE_NBYTES-1:0] strb);
        for (int b = 0; b < FE_NBYTES; b++) begin
            if (strb[b])
                base[8*b +: 8] = data[8*b +: 8];
        end
        return base;
    endfunction

    function automatic logic [FE_DATA_W-1:0] mem_word(input logic [WADDR_W-1:0] wa);
        return mem_data.exists(wa) ? mem_data[wa] : init_word(wa);
    endfunction

    // write-through means the latest merged value is always the read result
    function automatic logic [FE_DATA_W-1:0] exp_read(input logic [WADDR_W-1:0] wa);
        return ref_mem.exists(wa) ? ref_mem[wa] : init_word(wa);
    endfunction

    function automatic void shadow_lookup(input logic [WADDR_W-1:0] wa, input logic is_write);
        logic [LINE_OFF_W-1:0] idx;
        logic [WADDR_W-1:0]    tag;
        logic                  hit;
        idx = wa[WORD_OFF_W +: LINE_OFF_W];
        tag = wa >> (LINE_OFF_W + WORD_OFF_W);
        hit = sh_valid[idx] && (sh_tag[idx] == tag);
        if (is_write) begin
            event_count[hit ? CTRL_WR_HIT : CTRL_WR_MISS] += 1;
        end else begin
            // misses allocate on read only
            event_count[hit ? CTRL_RD_HIT : CTRL_RD_MISS] += 1;
            sh_valid[idx] = 1'b1;
            sh_tag[idx]   = tag;
        end
    endfunction

    task automatic issue_request(input fe_addr_u a, input logic [FE_DATA_W-1:0] d,
                                 input logic [FE_NBYTES-1:0] s, input int kind,
                                 input logic [FE_DATA_W-1:0] exp);
        @(posedge clk);
        #1;
        exp_q.push_back(exp);
        kind_q.push_back(kind);
        name_q.push_back(cur_test);
        valid = 1'b1;
        addr  = a;
        wdata = d;
        wstrb = s;
        do begin
            @(posedge clk);
            #1;
        end while (!ready);
        valid = 1'b0;
        addr  = '0;
        wdata = '0;
        wstrb = '0;
    endtask

    task automatic read_word(input logic [WADDR_W-1:0] wa);
        fe_addr_u a;
        a = '0;
        a.cache.word_addr = wa;
        shadow_lookup(wa, 1'b0);
        issue_request(a, '0, '0, KIND_WORD, exp_read(wa));
    endtask

    task automatic write_word(input logic [WADDR_W-1:0] wa, input logic [FE_DATA_W-1:0] d,
                              input logic [FE_NBYTES-1:0] s);
        fe_addr_u a;
        a = '0;
        a.cache.word_addr = wa;
        shadow_lookup(wa, 1'b1);
        ref_mem[wa] = merge_bytes(exp_read(wa), d, s);
        writes_issued++;
        issue_request(a, d, s, KIND_NONE, '0);
    endtask

    task automatic read_reg(input logic [CTRL_REG_W-1:0] r, input logic [FE_DATA_W-1:0] exp);
        fe_addr_u a;
        a = '0;
        a.ctrl.ctrl    = 1'b1;
        a.ctrl.reg_idx = r;
        issue_request(a, '0, '0, KIND_COUNT, exp);
    endtask

    task automatic write_reg(input logic [CTRL_REG_W-1:0] r, input logic [FE_DATA_W-1:0] d);
        fe_addr_u a;
        a = '0;
        a.ctrl.ctrl    = 1'b1;
        a.ctrl.reg_idx = r;
        issue_request(a, d, '1, KIND_NONE, '0);
    endtask

    task automatic verify_counters();
        for (int r = 0; r < 4; r++)
            read_reg(CTRL_REG_W'(r), event_count[r]);
    endtask

    // compares each answer in the cycle that ready is high
    always @(posedge clk) begin : compare
        logic [FE_DATA_W-1:0] exp;
        int                   kind;
        string                name;
        if (!reset && ready) begin
            if (kind_q.size() == 0) begin
                stop_with_error("ready pulsed with no request outstanding");
            end else begin
                exp  = exp_q.pop_front();
                kind = kind_q.pop_front();
                name = name_q.pop_front();
                if (kind == KIND_WORD)
                    check_word(name, exp, rdata);
                else if (kind == KIND_COUNT)
                    check_count(name, exp, rdata);
            end
        end
    end

    // memory port model, random wait before each ready pulse
    always @(posedge clk) begin : memory_model
        logic                 rst;
        logic                 v;
        logic                 r;
        logic [FE_ADDR_W-1:0] a;
        logic [FE_DATA_W-1:0] d;
        logic [FE_NBYTES-1:0] s;
        rst = reset;
        v   = mem_valid;
        r   = mem_ready;
        a   = mem_addr;
        d   = mem_wdata;
        s   = mem_wstrb;
        #1;
        if (rst) begin
            mem_ready = 1'b0;
            mem_busy  = 1'b0;
        end else if (v && r) begin
            mem_ready = 1'b0;
            mem_busy  = 1'b0;
            if (|s) begin
                mem_data[a[FE_ADDR_W-2:2]] = merge_bytes(mem_word(a[FE_ADDR_W-2:2]), d, s);
                mem_writes++;
            end
        end else if (v) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = lat_min + ($unsigned($random(seed)) % lat_span);
            end
            if (mem_wait == 0) begin
                mem_ready = 1'b1;
                mem_rdata = mem_word(a[FE_ADDR_W-2:2]);
            end else begin
                mem_wait--;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        stop_with_error($sformatf("timeout: test %s did not finish within %0d ns",
                                  cur_test, TIMEOUT_NS));
    end

    initial begin : stimulus
        logic [WADDR_W-1:0]   wa;
        logic [WADDR_W-1:0]   burst [$];
        logic [FE_NBYTES-1:0] strb;
        int                   op;
        int                   r;
        clk       = 1'b0;
        reset     = 1'b1;
        valid     = 1'b0;
        addr      = '0;
        wdata     = '0;
        wstrb     = '0;
        mem_rdata = '0;
        mem_ready = 1'b0;
        mem_busy  = 1'b0;
        mem_wait  = 0;
        mem_writes    = 0;
        writes_issued = 0;
        lat_min   = 0;
        lat_span  = 4;
        sh_valid  = '0;
        for (int i = 0; i < 4; i++)
            event_count[i] = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        cur_test = "reset_and_miss";
        check_flag(cur_test, 1'b1, wtb_empty_o);
        read_word(29'h40);
        read_word(29'h40);
        read_word(29'h41);

        // 0x40 hits, 0x90 misses and is not allocated by the writes
        cur_test = "partial_strobe";
        write_word(29'h40, 32'h1122_3344, 4'b0011);
        read_word(29'h40);
        write_word(29'h90, 32'haabb_ccdd, 4'b1100);
        write_word(29'h90, 32'h0000_ee00, 4'b0010);
        read_word(29'h90);
        write_word(29'h42, 32'h5566_7788, 4'b0100);
        read_word(29'h42);
        read_word(29'h41);

        cur_test = "counters";
        verify_counters();
        write_reg(3'd7, 32'hffff_ffff);
        read_reg(3'd7, '0);
        write_reg(CTRL_CLEAR, 32'h0000_000f);
        for (int i = 0; i < 4; i++)
            event_count[i] = '0;
        verify_counters();

        cur_test = "invalidate";
        read_word(29'h40);
        write_reg(CTRL_INVALIDATE, '0);
        sh_valid = '0;
        read_word(29'h40);
        read_word(29'h90);
        verify_counters();

        // slow memory, the buffer fills and writes stall
        cur_test = "write_burst";
        lat_min  = LAT_MAX - 6;
        lat_span = 6;
        for (int i = 0; i < 12; i++) begin
            wa = 29'h200 + i * 5;
            burst.push_back(wa);
            write_word(wa, $random(seed), 4'b1111 >> (i % 3));
        end
        // memory has seen every write once the counts meet
        while (mem_writes != writes_issued)
            @(posedge clk);
        @(posedge clk);
        #1;
        check_flag(cur_test, 1'b1, wtb_empty_o);
        foreach (burst[i])
            check_word(cur_test, exp_read(burst[i]), mem_word(burst[i]));
        read_reg(CTRL_STATUS, 32'd1);
        lat_min  = 0;
        lat_span = 4;
        foreach (burst[i])
            read_word(burst[i]);

        // four tags on two indices, so lines keep evicting each other
        cur_test = "random_mix";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            wa = WADDR_W'((32'h10 + $unsigned($random(seed)) % 4) << (LINE_OFF_W + WORD_OFF_W));
            wa[WORD_OFF_W +: LINE_OFF_W] = ($random(seed) & 1) ? 5 : 9;
            wa[WORD_OFF_W-1:0] = $random(seed);
            op = $unsigned($random(seed)) % 10;
            if (op < 5) begin
                read_word(wa);
            end else if (op < 8) begin
                strb = $random(seed);
                if (strb == '0)
                    strb = '1;
                write_word(wa, $random(seed), strb);
            end else if (op < 9) begin
                r = $unsigned($random(seed)) % 4;
                read_reg(CTRL_REG_W'(r), event_count[r]);
            end else begin
                write_reg(CTRL_INVALIDATE, '0);
                sh_valid = '0;
            end
        end
        verify_counters();

        repeat (2) @(posedge clk);
        if (kind_q.size() != 0) begin
            stop_with_error("requests finished without a response being checked");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

/* tb.f */
logic/dcache_pkg.sv
logic/cache_req_if.sv
logic/mem_write_if.sv
logic/line_refill_if.sv
logic/cache_frontend.sv
logic/cache_memory.sv
logic/cache_backend.sv
logic/cache_control.sv
logic/dcache.sv
verif/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - logic/dcache_pkg.sv
  - logic/cache_req_if.sv
  - logic/mem_write_if.sv
  - logic/line_refill_if.sv
  - logic/cache_frontend.sv
  - logic/cache_memory.sv
  - logic/cache_backend.sv
  - logic/cache_control.sv
  - logic/dcache.sv
  - target: test
    files:
      - verif/dcache_tb.sv
